/* dv/cpuControl_chk.sv */
`default_nettype none

module cpuControlChk
(
    input logic                  clk,
    input logic                  reset,
    input controlPkg::ctrlWord_t ctrl
);
    timeunit 1ns;
    timeprecision 1ps;
    import controlPkg::*;

    // fetch still holds in the cycle after reset releases
    assert property (@(posedge clk) disable iff (!reset)
        reset && ctrl.instrWrite |=> ctrl == '0)
        else $error("control word not idle in the cycle after fetch");
    assert property (@(posedge clk) disable iff (!reset) (ctrl.pcSrc != pcPlus) |-> ctrl.pcEn)
        else $error("pc source selected without pc enable");
    assert property (@(posedge clk) disable iff (!reset) !(ctrl.memWrite && ctrl.regWrite))
        else $error("memory write and register write active together");
    assert property (@(posedge clk) disable iff (!reset)
        reset && ctrl.instrWrite |=> !ctrl.instrWrite)
        else $error("instruction write held for two cycles");

endmodule

bind cpuControl cpuControlChk chk (.clk(clk), .reset(reset), .ctrl(ctrl));

`default_nettype wire

/* dv/tbCpuControl.sv */
`default_nettype none

module tbCpuControl;
    timeunit 1ns;
    timeprecision 1ps;
    import controlPkg::*;

    localparam int numInstr = 400;
    localparam int maxCycles = 8 + numInstr * 8 + 92; // reset, worst-case instructions, margin
    localparam int testEnd [5] = '{0, 100, 180, 330, 400}; // last instruction of each test
    string testNames [5] = '{"reset", "arithmetic", "memory", "condition", "undefined"};

    logic         clk;
    logic         reset;
    instrFields_t instr;
    psr_t         psr;
    ctrlWord_t    ctrl;
    ctrlWord_t    expected;
    logic [31:0]  seed = 32'hb523_5425;
    state_t       modelState = stFetch;
    instrClass_t  modelClass = clsNop;
    logic [3:0]   modelCond = 4'b0000;
    logic         fetchSeen = 1'b0;
    logic         done = 1'b0;
    int           issued = 0;
    int           cycles = 0;
    int           curTest = 0;
    int           testErrors = 0;
    int           failedTests = 0;

    cpuControl UUT (.clk(clk), .reset(reset), .instr(instr), .psr(psr), .ctrl(ctrl));

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8; // low bits of an LCG are weak
    endfunction

    function automatic instrClass_t classOf(instrFields_t f);
        case (f.op)
            opRegGroup:
                return (f.opExt inside {extAnd, extOr, extXor, extAdd, extSub}) ? clsAluReg
                    : (f.opExt == extCmp) ? clsCmp : (f.opExt == extMov) ? clsMov : clsNop;
            opShiftGroup: return (f.opExt == extLsh) ? clsAluReg : clsAluImm;
            opMemGroup:
                return (f.opExt == extLoad) ? clsLoad : (f.opExt == extStor) ? clsStore
                    : (f.opExt == extJal) ? clsJal
                    : (f.opExt == extJcond && f.cond != condNever) ? clsJcond : clsNop;
            opAndi, opOri, opXori, opAddi, opSubi, opLui: return clsAluImm;
            opCmpi: return clsCmpi;
            opMovi: return clsMovi;
            opBcond: return (f.cond != condNever) ? clsBcond : clsNop;
            default: return clsNop;
        endcase
    endfunction

    // indexed by condition code, 1111 never holds
    function automatic logic condHolds(logic [3:0] code, psr_t p);
        logic [15:0] t;
        t = {1'b0, 1'b1, p.zero | p.negative, ~p.negative & ~p.zero, p.low | p.zero,
             ~p.low & ~p.zero, ~p.flag, p.flag, ~p.negative, p.negative, ~p.low, p.low,
             ~p.carry, p.carry, ~p.zero, p.zero};
        return t[code];
    endfunction

    function automatic state_t nextOf(state_t s, instrClass_t c);
        case (s)
            stFetch: return stDecode;
            stDecode:
                return (c == clsJcond) ? stJumpCond : (c == clsBcond) ? stBranchCond
                    : (c == clsNop) ? stPcIncr : stRegLoad;
            stRegLoad:
                case (c)
                    clsAluReg: return stAluEx;
                    clsAluImm: return stImmEx;
                    clsCmp:    return stCmpEx;
                    clsCmpi:   return stCmpiEx;
                    clsMov:    return stMovEx;
                    clsMovi:   return stMoviEx;
                    clsLoad:   return stMemRead;
                    clsStore:  return stMemWrite;
                    default:   return stJalStorePc;
                endcase
            stAluEx, stImmEx, stMovEx, stMoviEx: return stWriteback;
            stMemRead: return stLoadWb;
            stJalStorePc: return stJalNewPc;
            stJumpCond, stBranchCond, stPcIncr: return stPcIncr2;
            stPcIncr2: return stPcIncr3;
            stPcIncr3: return stFetch;
            default: return stPcIncr;
        endcase
    endfunction

    function automatic ctrlWord_t expectedWord(state_t s, logic tk);
        ctrlWord_t w;
        w = '0;
        w.instrWrite = (s == stFetch);
        w.newAluInput = (s == stRegLoad);
        w.psrRegEn = (s inside {stCmpEx, stCmpiEx});
        w.regWrite = (s inside {stWriteback, stLoadWb, stJalStorePc});
        w.memWrite = (s == stMemWrite);
        w.writeBackSelect = (s == stLoadWb);
        w.dataToWriteSelect = (s == stJalStorePc);
        w.pcEn = (s inside {stJalNewPc, stPcIncr, stJumpCond, stBranchCond});
        if (s inside {stAluEx, stImmEx, stCmpEx, stCmpiEx})
            w.aluSrc1Sel = srcReg;
        if (s inside {stMovEx, stMoviEx})
            w.aluSrc1Sel = srcZero;
        if (s inside {stImmEx, stCmpiEx, stMoviEx})
            w.aluSrc2Sel = srcReg;
        if (s == stJalNewPc || (s == stJumpCond && tk))
            w.pcSrc = pcAbsolute;
        if (s == stBranchCond && tk)
            w.pcSrc = pcRelative;
        return w;
    endfunction

    // instruction number k picks its test's encoding group
    function automatic instrFields_t makeInstr(int k);
        instrFields_t f;
        int kind;
        logic [3:0] regExt [7] = '{extAnd, extOr, extXor, extAdd, extSub, extCmp, extMov};
        logic [3:0] immOp [6] = '{opAndi, opOri, opXori, opAddi, opSubi, opLui};
        logic [3:0] arithOp [5] = '{opRegGroup, opShiftGroup, opAndi, opCmpi, opMovi};
        logic [3:0] memExt [3] = '{extLoad, extStor, extJal};
        f = instrFields_t'(nextRand());
        kind = int'(nextRand() % 5);
        if (k <= testEnd[1])
        begin
            f.op = (kind == 2) ? immOp[nextRand() % 6] : arithOp[kind];
            if (kind == 0)
                f.opExt = regExt[nextRand() % 7];
        end
        else if (k <= testEnd[2])
        begin
            f.op = opMemGroup;
            f.opExt = memExt[nextRand() % 3];
        end
        else if (k <= testEnd[3])
        begin
            f.op = kind[0] ? opBcond : opMemGroup;
            f.opExt = extJcond;
        end
        else
        begin
            // jumps and branches with code 1111 belong to the condition test
            while (classOf(f) != clsNop || f.op == opBcond
                   || (f.op == opMemGroup && f.opExt == extJcond))
                f = instrFields_t'(nextRand());
        end
        return f;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        psr <= psr_t'(nextRand());
        if (fetchSeen && issued < numInstr)
        begin
            instr <= makeInstr(issued + 1); // held through decode
            issued <= issued + 1;
        end
    end

    always @(negedge clk)
    begin
        cycles++;
        if (modelState == stDecode)
        begin
            modelClass = classOf(instr);
            modelCond = instr.cond;
        end
        expected = expectedWord(modelState, condHolds(modelCond, psr));
        assert (ctrl == expected)
        else
        begin
            $display("Error: test %s expected %h actual %h", testNames[curTest], expected, ctrl);
            testErrors++;
        end
        fetchSeen = ctrl.instrWrite && reset;
        if (reset && modelState == stFetch && curTest < 5 && issued == testEnd[curTest])
        begin
            $display("test %s %s with %0d errors", testNames[curTest],
                     (testErrors == 0) ? "passed" : "failed", testErrors);
            if (testErrors != 0)
                failedTests++;
            testErrors = 0;
            curTest++;
            done = (curTest == 5);
        end
        if (reset)
            modelState = nextOf(modelState, modelClass);
        if (cycles >= maxCycles && !done)
        begin
            $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        reset = 1'b0;
        instr = '0;
        psr = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        wait (done);
        $display("%0d tests run, %0d passed, %0d failed", 5, 5 - failedTests, failedTests);
        if (failedTests == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/controlPkg.sv
source/instrDecode.sv
source/branchCondition.sv
source/mainFsm.sv
source/controlEncode.sv
source/cpuControl.sv
dv/cpuControl_chk.sv
dv/tbCpuControl.sv

/* run.sh */
#!/usr/bin/env bash
# builds the control unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tbCpuControl -o simCpuControl
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/simCpuControl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1

/* source/branchCondition.sv */
`default_nettype none

module branchCondition
(
    input  logic [3:0]       condCode,
    input  controlPkg::psr_t psr,
    output logic             taken
);
    import controlPkg::*;

    always_comb
    begin
        case (condCode)
            condEq: taken = psr.zero;
            condNe: taken = !psr.zero;
            condGe: taken = psr.zero || psr.negative;
            condCs: taken = psr.carry;
            condCc: taken = !psr.carry;
            condHi: taken = psr.low;
            condLs: taken = !psr.low;
            condLo: taken = !psr.low && !psr.zero;
            condHs: taken = psr.low || psr.zero;
            condGt: taken = psr.negative;  // negative flag doubles as signed greater
            condLe: taken = !psr.negative;
            condFs: taken = psr.flag;
            condFc: taken = !psr.flag;
            condLt: taken = !psr.negative && !psr.zero;
            condUc: taken = 1'b1;
            default: taken = 1'b0; // condNever
        endcase
    end

endmodule

`default_nettype wire

/* source/controlEncode.sv */
`default_nettype none

module controlEncode
(
    input  controlPkg::state_t    state,
    input  logic                  taken,
    output controlPkg::ctrlWord_t ctrl
);
    import controlPkg::*;

    always_comb
    begin
        ctrl = '0; // srcPc and pcPlus both encode as zero
        case (state)
            stFetch:   ctrl.instrWrite = 1'b1;
            stRegLoad: ctrl.newAluInput = 1'b1;
            stAluEx:   ctrl.aluSrc1Sel = srcReg;
            stImmEx:
            begin
                ctrl.aluSrc1Sel = srcReg;
                ctrl.aluSrc2Sel = srcReg;
            end
            stCmpEx:
            begin
                ctrl.aluSrc1Sel = srcReg;
                ctrl.psrRegEn   = 1'b1;
            end
            stCmpiEx:
            begin
                ctrl.aluSrc1Sel = srcReg;
                ctrl.aluSrc2Sel = srcReg;
                ctrl.psrRegEn   = 1'b1;
            end
            stMovEx:   ctrl.aluSrc1Sel = srcZero; // source plus zero
            stMoviEx:
            begin
                ctrl.aluSrc1Sel = srcZero;
                ctrl.aluSrc2Sel = srcReg;
            end
            stWriteback: ctrl.regWrite = 1'b1;
            stMemWrite:  ctrl.memWrite = 1'b1;
            stLoadWb:
            begin
                ctrl.writeBackSelect = 1'b1;
                ctrl.regWrite        = 1'b1;
            end
            stJalStorePc:
            begin
                ctrl.dataToWriteSelect = 1'b1; // link address goes to the register file
                ctrl.regWrite          = 1'b1;
            end
            stJalNewPc:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = pcAbsolute;
            end
            stPcIncr: ctrl.pcEn = 1'b1;
            stJumpCond:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = taken ? pcAbsolute : pcPlus;
            end
            stBranchCond:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = taken ? pcRelative : pcPlus;
            end
            default: ctrl = '0; // decode, memory read and the idle increments
        endcase
    end

endmodule

`default_nettype wire

/* source/controlPkg.sv */
`default_nettype none

package controlPkg;

    localparam int fieldWidth = 4;

    // opcodes
    localparam logic [fieldWidth-1:0] opRegGroup   = 4'b0000;
    localparam logic [fieldWidth-1:0] opAndi       = 4'b0001;
    localparam logic [fieldWidth-1:0] opOri        = 4'b0010;
    localparam logic [fieldWidth-1:0] opXori       = 4'b0011;
    localparam logic [fieldWidth-1:0] opMemGroup   = 4'b0100;
    localparam logic [fieldWidth-1:0] opAddi       = 4'b0101;
    localparam logic [fieldWidth-1:0] opShiftGroup = 4'b1000;
    localparam logic [fieldWidth-1:0] opSubi       = 4'b1001;
    localparam logic [fieldWidth-1:0] opCmpi       = 4'b1011;
    localparam logic [fieldWidth-1:0] opBcond      = 4'b1100;
    localparam logic [fieldWidth-1:0] opMovi       = 4'b1101;
    localparam logic [fieldWidth-1:0] opLui        = 4'b1111;

    // extensions for the register group
    localparam logic [fieldWidth-1:0] extAnd = 4'b0001;
    localparam logic [fieldWidth-1:0] extOr  = 4'b0010;
    localparam logic [fieldWidth-1:0] extXor = 4'b0011;
    localparam logic [fieldWidth-1:0] extAdd = 4'b0101;
    localparam logic [fieldWidth-1:0] extSub = 4'b1001;
    localparam logic [fieldWidth-1:0] extCmp = 4'b1011;
    localparam logic [fieldWidth-1:0] extMov = 4'b1101;

    localparam logic [fieldWidth-1:0] extLsh = 4'b0100; // register shift, others are immediate

    // extensions for the memory group
    localparam logic [fieldWidth-1:0] extLoad  = 4'b0000;
    localparam logic [fieldWidth-1:0] extStor  = 4'b0100;
    localparam logic [fieldWidth-1:0] extJal   = 4'b1000;
    localparam logic [fieldWidth-1:0] extJcond = 4'b1100;

    // condition codes
    localparam logic [fieldWidth-1:0] condEq    = 4'b0000;
    localparam logic [fieldWidth-1:0] condNe    = 4'b0001;
    localparam logic [fieldWidth-1:0] condCs    = 4'b0010;
    localparam logic [fieldWidth-1:0] condCc    = 4'b0011;
    localparam logic [fieldWidth-1:0] condHi    = 4'b0100;
    localparam logic [fieldWidth-1:0] condLs    = 4'b0101;
    localparam logic [fieldWidth-1:0] condGt    = 4'b0110;
    localparam logic [fieldWidth-1:0] condLe    = 4'b0111;
    localparam logic [fieldWidth-1:0] condFs    = 4'b1000;
    localparam logic [fieldWidth-1:0] condFc    = 4'b1001;
    localparam logic [fieldWidth-1:0] condLo    = 4'b1010;
    localparam logic [fieldWidth-1:0] condHs    = 4'b1011;
    localparam logic [fieldWidth-1:0] condLt    = 4'b1100;
    localparam logic [fieldWidth-1:0] condGe    = 4'b1101;
    localparam logic [fieldWidth-1:0] condUc    = 4'b1110;
    localparam logic [fieldWidth-1:0] condNever = 4'b1111;

    typedef struct packed {
        logic [fieldWidth-1:0] op;
        logic [fieldWidth-1:0] opExt;
        logic [fieldWidth-1:0] cond;
    } instrFields_t;

    typedef struct packed {
        logic [2:0] spare;
        logic       carry;
        logic       low;
        logic       flag;
        logic       zero;
        logic       negative;
    } psr_t;

    typedef enum logic [1:0] {srcPc = 2'b00, srcReg = 2'b01, srcZero = 2'b10} aluSrc_t;
    typedef enum logic [1:0] {pcPlus = 2'b00, pcAbsolute = 2'b01, pcRelative = 2'b10} pcSrc_t;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsCmp, clsCmpi, clsMov, clsMovi,
        clsLoad, clsStore, clsJal, clsJcond, clsBcond, clsNop
    } instrClass_t;

    typedef enum logic [4:0] {
        stFetch, stDecode, stRegLoad, stAluEx, stImmEx, stCmpEx, stCmpiEx,
        stMovEx, stMoviEx, stWriteback, stMemRead, stMemWrite, stLoadWb,
        stJalStorePc, stJalNewPc, stJumpCond, stBranchCond,
        stPcIncr, stPcIncr2, stPcIncr3
    } state_t;

    typedef struct packed {
        logic    memWrite;
        logic    pcEn;
        logic    writeBackSelect;
        logic    dataToWriteSelect;
        logic    newAluInput;
        logic    psrRegEn;
        logic    regWrite;
        logic    instrWrite;
        aluSrc_t aluSrc1Sel;
        aluSrc_t aluSrc2Sel;
        pcSrc_t  pcSrc;
    } ctrlWord_t;

endpackage

`default_nettype wire

/* source/cpuControl.sv */
`default_nettype none

module cpuControl
(
    input  logic                     clk,
    input  logic                     reset,
    input  controlPkg::instrFields_t instr,
    input  controlPkg::psr_t         psr,
    output controlPkg::ctrlWord_t    ctrl
);
    import controlPkg::*;

    instrClass_t instrClass;
    state_t      state;
    logic [3:0]  condCode;
    logic        taken;

    instrDecode decode (.instr(instr), .instrClass(instrClass));

    mainFsm fsm
    (
        .clk(clk),
        .reset(reset),
        .instrClass(instrClass),
        .condIn(instr.cond),
        .state(state),
        .condCode(condCode)
    );

    branchCondition branchEval (.condCode(condCode), .psr(psr), .taken(taken));

    controlEncode encode (.state(state), .taken(taken), .ctrl(ctrl));

endmodule

`default_nettype wire

/* source/instrDecode.sv */
`default_nettype none

module instrDecode
(
    input  controlPkg::instrFields_t instr,
    output controlPkg::instrClass_t  instrClass
);
    import controlPkg::*;

    always_comb
    begin
        instrClass = clsNop; // unlisted encodings fall through to a no-op
        case (instr.op)
            opRegGroup:
                case (instr.opExt)
                    extAnd, extOr, extXor, extAdd, extSub: instrClass = clsAluReg;
                    extCmp:  instrClass = clsCmp;
                    extMov:  instrClass = clsMov;
                    default: instrClass = clsNop;
                endcase
            opShiftGroup:
            begin
                if (instr.opExt == extLsh)
                    instrClass = clsAluReg;
                else
                    instrClass = clsAluImm; // shift by immediate
            end
            opMemGroup:
                case (instr.opExt)
                    extLoad: instrClass = clsLoad;
                    extStor: instrClass = clsStore;
                    extJal:  instrClass = clsJal;
                    extJcond:
                    begin
                        if (instr.cond == condNever)
                            instrClass = clsNop;
                        else
                            instrClass = clsJcond;
                    end
                    default: instrClass = clsNop;
                endcase
            opAndi, opOri, opXori, opAddi, opSubi, opLui: instrClass = clsAluImm;
            opCmpi: instrClass = clsCmpi;
            opMovi: instrClass = clsMovi;
            opBcond:
            begin
                // never-taken branch behaves like a no-op
                if (instr.cond == condNever)
                    instrClass = clsNop;
                else
                    instrClass = clsBcond;
            end
            default: instrClass = clsNop;
        endcase
    end

endmodule

`default_nettype wire

/* source/mainFsm.sv */
`default_nettype none

module mainFsm
(
    input  logic                    clk,
    input  logic                    reset,
    input  controlPkg::instrClass_t instrClass,
    input  logic [3:0]              condIn,
    output controlPkg::state_t      state,
    output logic [3:0]              condCode
);
    import controlPkg::*;

    state_t      nextState;
    instrClass_t classReg;

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= stFetch;
        else
            state <= nextState;
    end

    // instruction fields are only stable through decode, so keep what later states need
    always_ff @(posedge clk)
    begin
        if (state == stDecode)
        begin
            classReg <= instrClass;
            condCode <= condIn;
        end
    end

    always_comb
    begin
        nextState = stFetch;
        case (state)
            stFetch: nextState = stDecode;
            stDecode:
                case (instrClass)
                    clsJcond: nextState = stJumpCond;
                    clsBcond: nextState = stBranchCond;
                    clsNop:   nextState = stPcIncr;
                    default:  nextState = stRegLoad;
                endcase
            stRegLoad:
                case (classReg) // latched class picks the execute step
                    clsAluReg: nextState = stAluEx;
                    clsAluImm: nextState = stImmEx;
                    clsCmp:    nextState = stCmpEx;
                    clsCmpi:   nextState = stCmpiEx;
                    clsMov:    nextState = stMovEx;
                    clsMovi:   nextState = stMoviEx;
                    clsLoad:   nextState = stMemRead;
                    clsStore:  nextState = stMemWrite;
                    clsJal:    nextState = stJalStorePc;
                    default:   nextState = stPcIncr;
                endcase
            stAluEx, stImmEx, stMovEx, stMoviEx: nextState = stWriteback;
            stWriteback:  nextState = stPcIncr;
            stCmpEx, stCmpiEx: nextState = stPcIncr; // flags only, no writeback
            stMemRead:    nextState = stLoadWb;
            stLoadWb:     nextState = stPcIncr;
            stMemWrite:   nextState = stPcIncr;
            stJalStorePc: nextState = stJalNewPc;
            stJalNewPc:   nextState = stPcIncr;
            // jumps already wrote the pc, skip the first increment
            stJumpCond, stBranchCond: nextState = stPcIncr2;
            stPcIncr:     nextState = stPcIncr2;
            stPcIncr2:    nextState = stPcIncr3;
            stPcIncr3:    nextState = stFetch;
            default:      nextState = stFetch;
        endcase
    end

endmodule

`default_nettype wire
